// File: rtl/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

`define CORE_DATA_W      32
`define CORE_REG_N       32
`define CORE_MULT_STEPS  32

// Primary opcodes
`define CORE_OP_RTYPE    6'h00
`define CORE_OP_ADDI     6'h08
`define CORE_OP_ANDI     6'h0c
`define CORE_OP_ORI      6'h0d

// R-type funct codes
`define CORE_FN_ADD      6'h20
`define CORE_FN_SUB      6'h22
`define CORE_FN_AND      6'h24
`define CORE_FN_OR       6'h25
`define CORE_FN_SLT      6'h2a
`define CORE_FN_MULT     6'h18
`define CORE_FN_MULTU    6'h19
`define CORE_FN_MFHI     6'h10
`define CORE_FN_MFLO     6'h12

`endif

// File: rtl/corePkg.sv
`include "core_params.svh"

package corePkg;

    typedef logic [`CORE_DATA_W-1:0] dataWord;
    typedef logic [$clog2(`CORE_REG_N)-1:0] regIdx;
    typedef logic [2:0] aluOp;
    typedef logic [1:0] wbSel;

    typedef enum logic [1:0] {
        stIdle,
        stRun,
        stDone
    } multState;

    // ALU operation codes
    localparam aluOp aluAdd = 3'd0;
    localparam aluOp aluSub = 3'd1;
    localparam aluOp aluAnd = 3'd2;
    localparam aluOp aluOr  = 3'd3;
    localparam aluOp aluSlt = 3'd4;

    // Writeback value source
    localparam wbSel wbAlu = 2'd0;
    localparam wbSel wbLo  = 2'd1;
    localparam wbSel wbHi  = 2'd2;

endpackage

// File: rtl/aluUnit.sv
module aluUnit (
    input  corePkg::dataWord a,
    input  corePkg::dataWord b,
    input  corePkg::aluOp    op,
    output corePkg::dataWord y
);
    import corePkg::*;

    logic lessThan;

    // Signed compare for slt
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            aluAdd:  y = a + b;
            aluSub:  y = a - b;
            aluAnd:  y = a & b;
            aluOr:   y = a | b;
            aluSlt:  y = dataWord'(lessThan);
            default: y = '0;
        endcase
    end

endmodule

// File: rtl/seqMultiplier.sv
`include "core_params.svh"

module seqMultiplier (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  logic             signedMode,
    input  corePkg::dataWord srcA,
    input  corePkg::dataWord srcB,
    output corePkg::dataWord hi,
    output corePkg::dataWord lo,
    output logic             busy,
    output logic             done
);
    import corePkg::*;

    localparam int cntW = $clog2(`CORE_MULT_STEPS);
    localparam int msb  = `CORE_DATA_W - 1;

    multState                  state;
    logic [cntW-1:0]           count;
    dataWord                   magA;
    dataWord                   magB;
    dataWord                   mcand;
    dataWord                   accHi;
    dataWord                   accLo;
    logic                      negRes;
    logic [`CORE_DATA_W:0]     sum;
    logic [2*`CORE_DATA_W-1:0] prod;

    // Work on magnitudes, fix the sign at the end
    assign magA = (signedMode && srcA[msb]) ? -srcA : srcA;
    assign magB = (signedMode && srcB[msb]) ? -srcB : srcB;

    // One multiplier bit per cycle, LSB first
    assign sum  = {1'b0, accHi} + (accLo[0] ? {1'b0, mcand} : '0);
    assign prod = {sum, accLo[msb:1]};

    assign busy = (state == stRun) || (state == stIdle && start);
    assign done = (state == stDone);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= stIdle;
            count <= '0;
        end else begin
            case (state)
                stIdle: begin
                    if (start) begin
                        state <= stRun;
                        count <= cntW'(`CORE_MULT_STEPS - 1);
                    end
                end
                stRun: begin
                    if (count == '0) begin
                        state <= stDone;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == stIdle && start) begin
            mcand  <= magA;
            accHi  <= '0;
            accLo  <= magB;
            negRes <= signedMode && (srcA[msb] ^ srcB[msb]);
        end else if (state == stRun) begin
            {accHi, accLo} <= prod;
        end
    end

    // HI/LO change only when a multiply finishes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hi <= '0;
            lo <= '0;
        end else if (state == stRun && count == '0) begin
            {hi, lo} <= negRes ? -prod : prod;
        end
    end

endmodule

// File: rtl/decodeStage.sv
`include "core_params.svh"

module decodeStage (
    input  logic             clk,
    input  logic             rst,
    input  corePkg::dataWord instr,
    input  logic             instrValid,
    input  logic             stall,
    input  logic             wrEn,
    input  corePkg::regIdx   wrReg,
    input  corePkg::dataWord wrData,
    output logic             readyD,
    output logic             validD,
    output corePkg::regIdx   rsD,
    output corePkg::regIdx   rtD,
    output corePkg::regIdx   rdD,
    output corePkg::dataWord rd1D,
    output corePkg::dataWord rd2D,
    output corePkg::dataWord immD,
    output corePkg::aluOp    aluOpD,
    output logic             useImmD,
    output logic             regWriteD,
    output logic             multStartD,
    output logic             multSgnD,
    output corePkg::wbSel    wbSelD
);
    import corePkg::*;

    logic       started;
    dataWord    instrReg;
    dataWord    regs [`CORE_REG_N];
    logic [5:0] opcode;
    logic [5:0] funct;

    // Comes up one cycle after reset is released
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            started <= 1'b0;
            validD  <= 1'b0;
        end else begin
            started <= 1'b1;
            if (!stall) begin
                validD <= instrValid && readyD;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && instrValid) begin
            instrReg <= instr;
        end
    end

    assign readyD = started && !stall;

    assign opcode = instrReg[31:26];
    assign funct  = instrReg[5:0];
    assign rsD    = instrReg[25:21];
    assign rtD    = instrReg[20:16];
    assign rdD    = instrReg[15:11];

    always_comb begin
        aluOpD     = aluAdd;
        useImmD    = 1'b0;
        regWriteD  = 1'b0;
        multStartD = 1'b0;
        multSgnD   = 1'b0;
        wbSelD     = wbAlu;
        immD       = {{(`CORE_DATA_W-16){instrReg[15]}}, instrReg[15:0]};
        case (opcode)
            `CORE_OP_RTYPE: begin
                case (funct)
                    `CORE_FN_ADD:   regWriteD = 1'b1;
                    `CORE_FN_SUB: begin
                        regWriteD = 1'b1;
                        aluOpD    = aluSub;
                    end
                    `CORE_FN_AND: begin
                        regWriteD = 1'b1;
                        aluOpD    = aluAnd;
                    end
                    `CORE_FN_OR: begin
                        regWriteD = 1'b1;
                        aluOpD    = aluOr;
                    end
                    `CORE_FN_SLT: begin
                        regWriteD = 1'b1;
                        aluOpD    = aluSlt;
                    end
                    `CORE_FN_MULT: begin
                        multStartD = 1'b1;
                        multSgnD   = 1'b1;
                    end
                    `CORE_FN_MULTU: multStartD = 1'b1;
                    `CORE_FN_MFHI: begin
                        regWriteD = 1'b1;
                        wbSelD    = wbHi;
                    end
                    `CORE_FN_MFLO: begin
                        regWriteD = 1'b1;
                        wbSelD    = wbLo;
                    end
                    default: ;
                endcase
            end
            `CORE_OP_ADDI: begin
                regWriteD = 1'b1;
                useImmD   = 1'b1;
            end
            `CORE_OP_ANDI: begin
                regWriteD = 1'b1;
                useImmD   = 1'b1;
                aluOpD    = aluAnd;
                immD      = {{(`CORE_DATA_W-16){1'b0}}, instrReg[15:0]};
            end
            `CORE_OP_ORI: begin
                regWriteD = 1'b1;
                useImmD   = 1'b1;
                aluOpD    = aluOr;
                immD      = {{(`CORE_DATA_W-16){1'b0}}, instrReg[15:0]};
            end
            default: ;
        endcase
    end

    // Register file, r0 never written
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `CORE_REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrReg] <= wrData;
        end
    end

    // Write-through so a same-cycle write is seen
    assign rd1D = (wrEn && wrReg == rsD && rsD != '0) ? wrData : regs[rsD];
    assign rd2D = (wrEn && wrReg == rtD && rtD != '0) ? wrData : regs[rtD];

endmodule

// File: rtl/hazardControl.sv
module hazardControl (
    input  corePkg::regIdx rsE,
    input  corePkg::regIdx rtE,
    input  logic           regWriteW,
    input  corePkg::regIdx destW,
    input  logic           multBusy,
    input  logic           multDone,
    output logic           forwardA,
    output logic           forwardB,
    output logic           stall,
    output logic           flushE
);

    logic fwdValid;

    // Result stage is the only forwarding source
    assign fwdValid = regWriteW && (destW != '0);
    assign forwardA = fwdValid && (destW == rsE);
    assign forwardB = fwdValid && (destW == rtE);

    // Hold decode and execute until the multiply has retired
    assign stall = multBusy || multDone;

    // Finished multiply leaves execute as a bubble
    // while decode is still held
    assign flushE = multDone;

endmodule

// File: rtl/executeStage.sv
module executeStage (
    input  logic             clk,
    input  logic             rst,
    input  logic             validD,
    input  corePkg::regIdx   rsD,
    input  corePkg::regIdx   rtD,
    input  corePkg::regIdx   rdD,
    input  corePkg::dataWord rd1D,
    input  corePkg::dataWord rd2D,
    input  corePkg::dataWord immD,
    input  corePkg::aluOp    aluOpD,
    input  logic             useImmD,
    input  logic             regWriteD,
    input  logic             multStartD,
    input  logic             multSgnD,
    input  corePkg::wbSel    wbSelD,
    input  logic             stall,
    input  logic             flushE,
    input  logic             forwardA,
    input  logic             forwardB,
    input  corePkg::dataWord resultW,
    output corePkg::regIdx   rsE,
    output corePkg::regIdx   rtE,
    output corePkg::regIdx   destE,
    output logic             regWriteE,
    output corePkg::dataWord valueE,
    output logic             multBusy,
    output logic             multDone
);
    import corePkg::*;

    logic    multStartE;
    logic    multSgnE;
    logic    useImmE;
    regIdx   rdE;
    dataWord rd1E;
    dataWord rd2E;
    dataWord immE;
    aluOp    aluOpE;
    wbSel    wbSelE;
    dataWord srcA;
    dataWord fwdB;
    dataWord srcB;
    dataWord aluY;
    dataWord hi;
    dataWord lo;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            regWriteE  <= 1'b0;
            multStartE <= 1'b0;
        end else if (flushE) begin
            regWriteE  <= 1'b0;
            multStartE <= 1'b0;
        end else if (!stall) begin
            regWriteE  <= validD && regWriteD;
            multStartE <= validD && multStartD;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            rsE      <= rsD;
            rtE      <= rtD;
            rdE      <= rdD;
            rd1E     <= rd1D;
            rd2E     <= rd2D;
            immE     <= immD;
            aluOpE   <= aluOpD;
            useImmE  <= useImmD;
            multSgnE <= multSgnD;
            wbSelE   <= wbSelD;
        end
    end

    assign srcA  = forwardA ? resultW : rd1E;
    assign fwdB  = forwardB ? resultW : rd2E;
    assign srcB  = useImmE ? immE : fwdB;
    // I-type writes rt
    assign destE = useImmE ? rtE : rdE;

    aluUnit i_aluUnit (
        .a  (srcA),
        .b  (srcB),
        .op (aluOpE),
        .y  (aluY)
    );

    seqMultiplier i_seqMultiplier (
        .clk        (clk),
        .rst        (rst),
        .start      (multStartE),
        .signedMode (multSgnE),
        .srcA       (srcA),
        .srcB       (fwdB),
        .hi         (hi),
        .lo         (lo),
        .busy       (multBusy),
        .done       (multDone)
    );

    always_comb begin
        case (wbSelE)
            wbLo:    valueE = lo;
            wbHi:    valueE = hi;
            default: valueE = aluY;
        endcase
    end

endmodule

// File: rtl/resultStage.sv
module resultStage (
    input  logic             clk,
    input  logic             rst,
    input  logic             regWriteE,
    input  corePkg::regIdx   destE,
    input  corePkg::dataWord valueE,
    output logic             wrEn,
    output corePkg::regIdx   wrReg,
    output corePkg::dataWord wrData,
    output logic             commitValid,
    output corePkg::regIdx   commitReg,
    output corePkg::dataWord commitData
);
    import corePkg::*;

    logic    validR;
    regIdx   destR;
    dataWord valueR;

    // r0 writes are dropped here
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            validR <= 1'b0;
        end else begin
            validR <= regWriteE && (destE != '0);
        end
    end

    always_ff @(posedge clk) begin
        destR  <= destE;
        valueR <= valueE;
    end

    assign wrEn        = validR;
    assign wrReg       = destR;
    assign wrData      = valueR;
    assign commitValid = validR;
    assign commitReg   = destR;
    assign commitData  = valueR;

endmodule

// File: rtl/execCoreTop.sv
module execCoreTop (
    input  logic             clk,
    input  logic             rst,
    input  corePkg::dataWord instr,
    input  logic             instrValid,
    output logic             ready,
    output logic             commitValid,
    output corePkg::regIdx   commitReg,
    output corePkg::dataWord commitData
);
    import corePkg::*;

    logic    validD;
    regIdx   rsD;
    regIdx   rtD;
    regIdx   rdD;
    dataWord rd1D;
    dataWord rd2D;
    dataWord immD;
    aluOp    aluOpD;
    logic    useImmD;
    logic    regWriteD;
    logic    multStartD;
    logic    multSgnD;
    wbSel    wbSelD;
    logic    stall;
    logic    flushE;
    logic    forwardA;
    logic    forwardB;
    regIdx   rsE;
    regIdx   rtE;
    regIdx   destE;
    logic    regWriteE;
    dataWord valueE;
    logic    multBusy;
    logic    multDone;
    logic    wrEn;
    regIdx   wrReg;
    dataWord wrData;

    decodeStage i_decodeStage (
        .clk        (clk),
        .rst        (rst),
        .instr      (instr),
        .instrValid (instrValid),
        .stall      (stall),
        .wrEn       (wrEn),
        .wrReg      (wrReg),
        .wrData     (wrData),
        .readyD     (ready),
        .validD     (validD),
        .rsD        (rsD),
        .rtD        (rtD),
        .rdD        (rdD),
        .rd1D       (rd1D),
        .rd2D       (rd2D),
        .immD       (immD),
        .aluOpD     (aluOpD),
        .useImmD    (useImmD),
        .regWriteD  (regWriteD),
        .multStartD (multStartD),
        .multSgnD   (multSgnD),
        .wbSelD     (wbSelD)
    );

    hazardControl i_hazardControl (
        .rsE       (rsE),
        .rtE       (rtE),
        .regWriteW (wrEn),
        .destW     (wrReg),
        .multBusy  (multBusy),
        .multDone  (multDone),
        .forwardA  (forwardA),
        .forwardB  (forwardB),
        .stall     (stall),
        .flushE    (flushE)
    );

    executeStage i_executeStage (
        .clk        (clk),
        .rst        (rst),
        .validD     (validD),
        .rsD        (rsD),
        .rtD        (rtD),
        .rdD        (rdD),
        .rd1D       (rd1D),
        .rd2D       (rd2D),
        .immD       (immD),
        .aluOpD     (aluOpD),
        .useImmD    (useImmD),
        .regWriteD  (regWriteD),
        .multStartD (multStartD),
        .multSgnD   (multSgnD),
        .wbSelD     (wbSelD),
        .stall      (stall),
        .flushE     (flushE),
        .forwardA   (forwardA),
        .forwardB   (forwardB),
        .resultW    (wrData),
        .rsE        (rsE),
        .rtE        (rtE),
        .destE      (destE),
        .regWriteE  (regWriteE),
        .valueE     (valueE),
        .multBusy   (multBusy),
        .multDone   (multDone)
    );

    resultStage i_resultStage (
        .clk         (clk),
        .rst         (rst),
        .regWriteE   (regWriteE),
        .destE       (destE),
        .valueE      (valueE),
        .wrEn        (wrEn),
        .wrReg       (wrReg),
        .wrData      (wrData),
        .commitValid (commitValid),
        .commitReg   (commitReg),
        .commitData  (commitData)
    );

endmodule

// File: verification/execCore_assertions.sv
`include "core_params.svh"

module execCoreAssertions (
    input logic             clk,
    input logic             rst,
    input corePkg::dataWord instr,
    input logic             instrValid,
    input logic             ready,
    input logic             stall,
    input logic             multBusy,
    input logic             multDone,
    input logic             commitValid,
    input corePkg::regIdx   commitReg
);
    timeunit 1ns;
    timeprecision 100ps;
    import corePkg::*;

    logic  acc1;
    logic  acc2;
    logic  acc3;
    logic  multHeld;
    regIdx dst1;
    regIdx dst2;
    regIdx dst3;
    int    stallCycles;
    int    failHandshake = 0;
    int    failReset = 0;
    int    failStall = 0;
    int    failLatency = 0;
    int    failCount;

    // True for an encoding that writes a nonzero register
    function automatic logic writesReg(input dataWord w);
        logic [5:0] fn;
        fn = w[5:0];
        case (w[31:26])
            `CORE_OP_RTYPE:
                return (w[15:11] != 5'd0) && (fn == `CORE_FN_ADD || fn == `CORE_FN_SUB ||
                    fn == `CORE_FN_AND || fn == `CORE_FN_OR || fn == `CORE_FN_SLT ||
                    fn == `CORE_FN_MFHI || fn == `CORE_FN_MFLO);
            `CORE_OP_ADDI, `CORE_OP_ANDI, `CORE_OP_ORI:
                return w[20:16] != 5'd0;
            default:
                return 1'b0;
        endcase
    endfunction

    // mult or multu
    function automatic logic isMultiply(input dataWord w);
        return (w[31:26] == `CORE_OP_RTYPE) &&
            (w[5:0] == `CORE_FN_MULT || w[5:0] == `CORE_FN_MULTU);
    endfunction

    // Tracks accepted writes that were not held in decode
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc1        <= 1'b0;
            acc2        <= 1'b0;
            acc3        <= 1'b0;
            stallCycles <= 0;
        end else begin
            acc1        <= instrValid && ready && writesReg(instr);
            acc2        <= acc1 && !stall;
            acc3        <= acc2;
            stallCycles <= stall ? stallCycles + 1 : 0;
        end
    end

    // A multiply sitting in decode
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            multHeld <= 1'b0;
        end else if (!stall) begin
            multHeld <= instrValid && ready && isMultiply(instr);
        end
    end

    always_ff @(posedge clk) begin
        dst1 <= (instr[31:26] == `CORE_OP_RTYPE) ? instr[15:11] : instr[20:16];
        dst2 <= dst1;
        dst3 <= dst2;
    end

    assign failCount = failHandshake + failReset + failStall + failLatency;

    holdUnderBackPressure: assert property (@(posedge clk) disable iff (rst)
        instrValid && !ready |=> instrValid && $stable(instr))
        else begin
            failHandshake++;
            $error("instr or instrValid changed while ready was low");
        end

    idleInReset: assert property (@(posedge clk)
        rst |-> !commitValid && !ready && !multBusy)
        else begin
            failReset++;
            $error("commit, ready or multiplier active during reset");
        end

    readyAfterReset: assert property (@(posedge clk) $fell(rst) |=> ready)
        else begin
            failReset++;
            $error("ready did not rise after reset release");
        end

    // Multiply moving into execute takes ready away
    readyDropsForMult: assert property (@(posedge clk) disable iff (rst)
        multHeld && !stall |=> !ready && multBusy)
        else begin
            failStall++;
            $error("ready stayed high after a multiply entered execute");
        end

    // Done arrives after the full iteration count
    doneAfterSteps: assert property (@(posedge clk) disable iff (rst)
        multDone |-> stallCycles == `CORE_MULT_STEPS + 1)
        else begin
            failStall++;
            $error("multiplier done after the wrong number of stall cycles");
        end

    readyAfterDone: assert property (@(posedge clk) disable iff (rst)
        multDone |=> ready && !multDone)
        else begin
            failStall++;
            $error("ready did not return after the multiply finished");
        end

    threeCycleCommit: assert property (@(posedge clk) disable iff (rst)
        acc3 |-> commitValid && commitReg == dst3)
        else begin
            failLatency++;
            $error("write did not commit three cycles after acceptance");
        end

endmodule

bind execCoreTop execCoreAssertions i_execCoreAssertions (
    .clk         (clk),
    .rst         (rst),
    .instr       (instr),
    .instrValid  (instrValid),
    .ready       (ready),
    .stall       (stall),
    .multBusy    (multBusy),
    .multDone    (multDone),
    .commitValid (commitValid),
    .commitReg   (commitReg)
);

// File: verification/execCoreChecker.sv
`include "core_params.svh"

module execCoreChecker (
    input  logic             clk,
    input  logic             rst,
    input  corePkg::dataWord instr,
    input  logic             instrValid,
    input  logic             ready,
    input  logic             commitValid,
    input  corePkg::regIdx   commitReg,
    input  corePkg::dataWord commitData,
    output int               errorCount,
    output int               commitCount,
    output int               pendingCount
);
    timeunit 1ns;
    timeprecision 100ps;
    import corePkg::*;

    localparam int msb = `CORE_DATA_W - 1;

    dataWord modelRegs [`CORE_REG_N];
    dataWord modelHi;
    dataWord modelLo;
    regIdx   expReg [$];
    dataWord expData [$];
    int      errors = 0;
    int      commits = 0;
    int      pending = 0;

    assign errorCount   = errors;
    assign commitCount  = commits;
    assign pendingCount = pending;

    // In-order model, runs each instruction when it is accepted
    task automatic applyInstr(input dataWord w);
        logic [5:0]              fn;
        regIdx                   rs;
        regIdx                   rt;
        regIdx                   dst;
        dataWord                 a;
        dataWord                 b;
        dataWord                 val;
        logic [2*`CORE_DATA_W-1:0] prod;
        logic                    writes;
        fn     = w[5:0];
        rs     = w[25:21];
        rt     = w[20:16];
        dst    = w[15:11];
        a      = modelRegs[rs];
        b      = modelRegs[rt];
        val    = '0;
        writes = 1'b0;
        case (w[31:26])
            `CORE_OP_RTYPE: begin
                writes = 1'b1;
                case (fn)
                    `CORE_FN_ADD:  val = a + b;
                    `CORE_FN_SUB:  val = a - b;
                    `CORE_FN_AND:  val = a & b;
                    `CORE_FN_OR:   val = a | b;
                    `CORE_FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    `CORE_FN_MFHI: val = modelHi;
                    `CORE_FN_MFLO: val = modelLo;
                    `CORE_FN_MULT: begin
                        prod = $signed({{`CORE_DATA_W{a[msb]}}, a}) *
                            $signed({{`CORE_DATA_W{b[msb]}}, b});
                        {modelHi, modelLo} = prod;
                        writes = 1'b0;
                    end
                    `CORE_FN_MULTU: begin
                        prod = {{`CORE_DATA_W{1'b0}}, a} * {{`CORE_DATA_W{1'b0}}, b};
                        {modelHi, modelLo} = prod;
                        writes = 1'b0;
                    end
                    default: writes = 1'b0;
                endcase
            end
            `CORE_OP_ADDI: begin
                writes = 1'b1;
                dst    = rt;
                val    = a + {{(`CORE_DATA_W-16){w[15]}}, w[15:0]};
            end
            `CORE_OP_ANDI: begin
                writes = 1'b1;
                dst    = rt;
                val    = a & {{(`CORE_DATA_W-16){1'b0}}, w[15:0]};
            end
            `CORE_OP_ORI: begin
                writes = 1'b1;
                dst    = rt;
                val    = a | {{(`CORE_DATA_W-16){1'b0}}, w[15:0]};
            end
            default: writes = 1'b0;
        endcase
        // r0 stays zero and never commits
        if (writes && dst != '0) begin
            modelRegs[dst] = val;
            expReg.push_back(dst);
            expData.push_back(val);
        end
    endtask

    task automatic checkCommit();
        regIdx   wantReg;
        dataWord wantData;
        commits++;
        if (expReg.size() == 0) begin
            errors++;
            $display("Commit to register %0d at %0t with no write expected", commitReg, $time);
        end else begin
            wantReg  = expReg.pop_front();
            wantData = expData.pop_front();
            if (commitReg !== wantReg) begin
                errors++;
                $display("** Error commitReg: got %h, expected %h at %0t",
                    commitReg, wantReg, $time);
            end
            if (commitData !== wantData) begin
                errors++;
                $display("** Error commitData: got %h, expected %h at %0t",
                    commitData, wantData, $time);
            end
        end
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `CORE_REG_N; i++) begin
                modelRegs[i] = '0;
            end
            modelHi = '0;
            modelLo = '0;
            expReg.delete();
            expData.delete();
        end else begin
            // Older commit first, then the newly accepted word
            if (commitValid) begin
                checkCommit();
            end
            if (instrValid && ready) begin
                applyInstr(instr);
            end
        end
        pending = expReg.size();
    end

endmodule

// File: verification/execCoreTb.sv
`include "core_params.svh"

module execCoreTb;
    timeunit 1ns;
    timeprecision 100ps;
    import corePkg::*;

    localparam int clkPeriod  = 4;
    localparam int numInstr   = 300;
    localparam int drainLimit = 200;

    logic    clk;
    logic    rst;
    dataWord instr;
    logic    instrValid;
    logic    ready;
    logic    commitValid;
    regIdx   commitReg;
    dataWord commitData;
    int      errorCount;
    int      commitCount;
    int      pendingCount;
    int      tbErrors;
    int      assertFails;
    int      seed;

    execCoreTop i_execCoreTop (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .instrValid  (instrValid),
        .ready       (ready),
        .commitValid (commitValid),
        .commitReg   (commitReg),
        .commitData  (commitData)
    );

    execCoreChecker i_execCoreChecker (
        .clk          (clk),
        .rst          (rst),
        .instr        (instr),
        .instrValid   (instrValid),
        .ready        (ready),
        .commitValid  (commitValid),
        .commitReg    (commitReg),
        .commitData   (commitData),
        .errorCount   (errorCount),
        .commitCount  (commitCount),
        .pendingCount (pendingCount)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // Allows 40 cycles per instruction
    initial begin
        #(numInstr * 40 * clkPeriod);
        $display("Timeout, run not finished after %0d cycles", numInstr * 40);
        $display("Finished with errors");
        $finish;
    end

    // Registers limited to r0..r7 for frequent dependencies
    function automatic dataWord randomInstr();
        int          kind;
        logic [31:0] r;
        regIdx       rs;
        regIdx       rt;
        regIdx       rd;
        logic [5:0]  fn;
        kind = $unsigned($random(seed)) % 16;
        r    = $random(seed);
        rs   = {2'b00, r[2:0]};
        rt   = {2'b00, r[5:3]};
        rd   = {2'b00, r[8:6]};
        case (kind)
            0:       fn = `CORE_FN_ADD;
            1:       fn = `CORE_FN_SUB;
            2:       fn = `CORE_FN_AND;
            3:       fn = `CORE_FN_OR;
            4:       fn = `CORE_FN_SLT;
            5:       fn = `CORE_FN_MULT;
            6:       fn = `CORE_FN_MULTU;
            7:       fn = `CORE_FN_MFHI;
            8:       fn = `CORE_FN_MFLO;
            12:      fn = 6'h21;  // unsupported funct, a bubble
            default: fn = 6'h00;
        endcase
        case (kind)
            9, 14:   return {`CORE_OP_ADDI, rs, rt, r[31:16]};
            10:      return {`CORE_OP_ANDI, rs, rt, r[31:16]};
            11, 15:  return {`CORE_OP_ORI, rs, rt, r[31:16]};
            13:      return {6'h23, r[25:0]};
            default: return {`CORE_OP_RTYPE, rs, rt, rd, 5'd0, fn};
        endcase
    endfunction

    // Called at a falling edge, returns at the falling edge after acceptance
    task automatic issue(input dataWord w);
        instr      = w;
        instrValid = 1'b1;
        while (!ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        instrValid = 1'b0;
    endtask

    initial begin
        int gap;
        int waited;
        seed       = 32'h37cd;
        rst        = 1'b1;
        instr      = '0;
        instrValid = 1'b0;
        tbErrors   = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int n = 0; n < numInstr; n++) begin
            issue(randomInstr());
            gap = $unsigned($random(seed)) % 8;
            if (gap < 3) begin
                repeat (gap + 1) @(negedge clk);
            end
        end

        waited = 0;
        while (pendingCount != 0 && waited < drainLimit) begin
            @(negedge clk);
            waited++;
        end
        if (pendingCount != 0) begin
            tbErrors++;
            $display("%0d expected commits never arrived", pendingCount);
        end
        // Window for any extra commit
        repeat (10) @(negedge clk);

        assertFails = i_execCoreTop.i_execCoreAssertions.failCount;
        $display("Commits %0d, compare errors %0d, end-of-run errors %0d, assertion failures %0d",
            commitCount, errorCount, tbErrors, assertFails);
        if (errorCount + tbErrors + assertFails == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+rtl
rtl/corePkg.sv
rtl/aluUnit.sv
rtl/seqMultiplier.sv
rtl/decodeStage.sv
rtl/hazardControl.sv
rtl/executeStage.sv
rtl/resultStage.sv
rtl/execCoreTop.sv
verification/execCore_assertions.sv
verification/execCoreChecker.sv
verification/execCoreTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the execCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module execCoreTb -f sim.f -o execCoreSim > compile.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat compile.log
    echo "Verilator compile failed with status $status"
    exit 1
fi

./obj_dir/execCoreSim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" sim.log; then
    exit 1
fi
exit 0
